// File: common/dual_core_settings.svh
`ifndef DUAL_CORE_SETTINGS_SVH
`define DUAL_CORE_SETTINGS_SVH

// data path and instruction word
`define DATA_W 32

// register file index, 32 registers
`define REG_IDX_W 5

// per-core instruction memory, 32 words
`define IMEM_ADDR_W 5

// shared data memory, 256 words
`define DMEM_ADDR_W 8

// constant field in the low instruction bits
`define IMM_W 15

`endif

// File: common/core_pkg.sv
`default_nettype none
`include "dual_core_settings.svh"

package core_pkg;

	typedef logic [`DATA_W-1:0] word_t;         // data or instruction word
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`IMEM_ADDR_W-1:0] pc_t;
	typedef logic [`DMEM_ADDR_W-1:0] dmem_addr_t; // word address, not byte

	// opcode field, bits 31:26
	// anything above OP_SW decodes as a halt
	typedef enum logic [5:0] {
		OP_HALT = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_XOR  = 6'd5,
		OP_SLT  = 6'd6,   // signed compare
		OP_ADDI = 6'd7,
		OP_LW   = 6'd8,
		OP_SW   = 6'd9
	} op_t;

endpackage

`default_nettype wire

// File: core/core_alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "dual_core_settings.svh"

module core_alu import core_pkg::*; (
	input wire word_t instr,
	input wire word_t rs_val,
	input wire word_t rt_val,
	output op_t op,
	output reg_idx_t dest,
	output logic writes_reg,
	output logic is_load,
	output logic is_store,
	output word_t result
);

	logic [5:0] opcode;
	reg_idx_t rt;
	reg_idx_t rd;
	logic [`IMM_W-1:0] imm;
	word_t imm_ext;

	assign opcode = instr[31:26];
	assign rt = instr[19:15];
	assign rd = instr[14:10];   // overlaps the top of the constant
	assign imm = instr[`IMM_W-1:0];
	assign imm_ext = {{(`DATA_W-`IMM_W){imm[`IMM_W-1]}}, imm};

	// unknown opcodes fold into halt
	always_comb begin
		if (opcode <= OP_SW)
			op = op_t'(opcode);
		else
			op = OP_HALT;
	end

	always_comb begin
		result = '0;
		dest = rd;
		writes_reg = 1'b1;
		is_load = 1'b0;
		is_store = 1'b0;
		case (op)
			OP_ADD: result = rs_val + rt_val;
			OP_SUB: result = rs_val - rt_val;
			OP_AND: result = rs_val & rt_val;
			OP_OR: result = rs_val | rt_val;
			OP_XOR: result = rs_val ^ rt_val;
			OP_SLT: result = word_t'($signed(rs_val) < $signed(rt_val));
			OP_ADDI: begin
				result = rs_val + imm_ext;
				dest = rt;
			end
			OP_LW: begin
				result = rs_val + imm_ext;   // effective address
				dest = rt;
				is_load = 1'b1;
			end
			OP_SW: begin
				result = rs_val + imm_ext;
				writes_reg = 1'b0;
				is_store = 1'b1;
			end
			default: writes_reg = 1'b0;   // halt
		endcase

		// r0 is hardwired to zero, so a write to it is dropped here
		if (dest == '0)
			writes_reg = 1'b0;
	end

endmodule

`default_nettype wire

// File: core/core_pipeline.sv
`timescale 1ns/100ps
`default_nettype none
`include "dual_core_settings.svh"

module core_pipeline import core_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic prog_we,
	input wire pc_t prog_addr,
	input wire word_t prog_data,
	input wire logic mem_ack,
	input wire word_t mem_rdata,
	output logic mem_req,
	output logic mem_we,
	output dmem_addr_t mem_addr,
	output word_t mem_wdata,
	output logic done
);

	word_t imem [0:(1<<`IMEM_ADDR_W)-1];
	word_t rf [0:(1<<`REG_IDX_W)-1];

	pc_t pc;
	word_t fetch_word;
	logic fetch_halt;

	logic fd_valid;
	word_t fd_instr;
	reg_idx_t fd_rs;
	reg_idx_t fd_rt;
	word_t rs_val;
	word_t rt_val;

	op_t dec_op;
	reg_idx_t dec_dest;
	logic dec_writes;
	logic dec_load;
	logic dec_store;
	word_t dec_result;
	logic uses_rt;

	logic mw_valid;
	logic mw_halt;
	logic mw_writes;
	logic mw_load;
	logic mw_store;
	reg_idx_t mw_dest;
	word_t mw_result;
	word_t mw_wdata;
	word_t wb_data;

	logic mem_wait;
	logic load_use;

	// program load port
	always_ff @(posedge clk) begin
		if (prog_we)
			imem[prog_addr] <= prog_data;
	end

	// fetch stops advancing once it sees the halt word
	assign fetch_word = imem[pc];
	assign fetch_halt = (fetch_word[31:26] == OP_HALT) || (fetch_word[31:26] > OP_SW);

	// memory stage holds the whole core until ack
	assign mem_wait = mw_valid && (mw_load || mw_store) && !mem_ack;

	assign uses_rt = dec_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SW};
	assign load_use = fd_valid && mw_valid && mw_load && mw_writes &&
		(((dec_op != OP_HALT) && (fd_rs == mw_dest)) || (uses_rt && (fd_rt == mw_dest)));

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			fd_valid <= 1'b0;
		end else if (!mem_wait && !load_use) begin
			fd_valid <= run;
			if (run && !fetch_halt)
				pc <= pc + pc_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_wait && !load_use)
			fd_instr <= fetch_word;
	end

	assign fd_rs = fd_instr[24:20];
	assign fd_rt = fd_instr[19:15];

	// value leaving the last stage, also bypassed into decode
	assign wb_data = mw_load ? mem_rdata : mw_result;
	assign rs_val = (mw_valid && mw_writes && (mw_dest == fd_rs)) ? wb_data : rf[fd_rs];
	assign rt_val = (mw_valid && mw_writes && (mw_dest == fd_rt)) ? wb_data : rf[fd_rt];

	core_alu u_alu (
		.instr      (fd_instr),
		.rs_val     (rs_val),
		.rt_val     (rt_val),
		.op         (dec_op),
		.dest       (dec_dest),
		.writes_reg (dec_writes),
		.is_load    (dec_load),
		.is_store   (dec_store),
		.result     (dec_result)
	);

	always_ff @(posedge clk) begin
		if (rst)
			rf <= '{default: '0};
		else if (mw_valid && mw_writes && !mem_wait)
			rf[mw_dest] <= wb_data;
	end

	// a load-use hit turns into a bubble here
	always_ff @(posedge clk) begin
		if (rst)
			mw_valid <= 1'b0;
		else if (!mem_wait)
			mw_valid <= fd_valid && !load_use;
	end

	always_ff @(posedge clk) begin
		if (!mem_wait) begin
			mw_halt <= (dec_op == OP_HALT);
			mw_writes <= dec_writes;
			mw_load <= dec_load;
			mw_store <= dec_store;
			mw_dest <= dec_dest;
			mw_result <= dec_result;
			mw_wdata <= rt_val;   // store data
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			done <= 1'b0;
		else if (mw_valid && mw_halt)
			done <= 1'b1;   // sticky until reset
	end

	assign mem_req = mw_valid && (mw_load || mw_store);
	assign mem_we = mw_store;
	assign mem_addr = mw_result[`DMEM_ADDR_W-1:0];
	assign mem_wdata = mw_wdata;

	// request fields stay put while waiting on the arbiter
	req_held: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr) &&
			$stable(mem_wdata));

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "dual_core_settings.svh"

module mem_arbiter import core_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic req0,
	input wire logic we0,
	input wire dmem_addr_t addr0,
	input wire word_t wdata0,
	input wire logic req1,
	input wire logic we1,
	input wire dmem_addr_t addr1,
	input wire word_t wdata1,
	input wire word_t ram_rdata,
	output logic ack0,
	output logic ack1,
	output word_t rdata0,
	output word_t rdata1,
	output logic ram_en,
	output logic ram_we,
	output dmem_addr_t ram_addr,
	output word_t ram_wdata
);

	logic last;       // core granted most recently and acked next
	logic ack_pend;   // access from last cycle being acked now
	logic elig0;
	logic elig1;
	logic sel;

	// a core still holds req in its ack cycle, so skip it then
	assign elig0 = req0 && !(ack_pend && !last);
	assign elig1 = req1 && !(ack_pend && last);

	always_comb begin
		if (elig0 && elig1)
			sel = ~last;   // round robin on a tie
		else
			sel = elig1;
	end

	assign ram_en = elig0 || elig1;
	assign ram_we = sel ? we1 : we0;
	assign ram_addr = sel ? addr1 : addr0;
	assign ram_wdata = sel ? wdata1 : wdata0;

	always_ff @(posedge clk) begin
		if (rst) begin
			last <= 1'b0;
			ack_pend <= 1'b0;
		end else begin
			ack_pend <= ram_en;
			if (ram_en)
				last <= sel;
		end
	end

	assign ack0 = ack_pend && !last;
	assign ack1 = ack_pend && last;
	assign rdata0 = ram_rdata;   // valid with ack0
	assign rdata1 = ram_rdata;

	one_ack: assert property (@(posedge clk) disable iff (rst) !(ack0 && ack1));

	// an ack only goes to a core that still holds its request
	ack_to_requester: assert property (@(posedge clk) disable iff (rst)
		(!ack0 || req0) && (!ack1 || req1));

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/100ps
`default_nettype none
`include "dual_core_settings.svh"

module data_ram import core_pkg::*; (
	input wire logic clk,
	input wire logic en,
	input wire logic we,
	input wire dmem_addr_t addr,
	input wire word_t wdata,
	input wire dmem_addr_t dbg_addr,
	output word_t rdata,
	output word_t dbg_data
);

	word_t mem [0:(1<<`DMEM_ADDR_W)-1];

	// registered read, old data on a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

	assign dbg_data = mem[dbg_addr];   // inspection port

endmodule

`default_nettype wire

// File: hdl/dual_core_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "dual_core_settings.svh"

module dual_core_top import core_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic prog_we,
	input wire logic prog_core,
	input wire pc_t prog_addr,
	input wire word_t prog_data,
	input wire dmem_addr_t dbg_addr,
	output word_t dbg_data,
	output logic done0,
	output logic done1
);

	logic prog_we0;
	logic prog_we1;
	logic c0_req;
	logic c0_we;
	dmem_addr_t c0_addr;
	word_t c0_wdata;
	logic c0_ack;
	word_t c0_rdata;
	logic c1_req;
	logic c1_we;
	dmem_addr_t c1_addr;
	word_t c1_wdata;
	logic c1_ack;
	word_t c1_rdata;
	logic ram_en;
	logic ram_we;
	dmem_addr_t ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;

	// program load goes to the selected core only
	assign prog_we0 = prog_we && !prog_core;
	assign prog_we1 = prog_we && prog_core;

	core_pipeline u_core0 (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.prog_we   (prog_we0),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.mem_ack   (c0_ack),
		.mem_rdata (c0_rdata),
		.mem_req   (c0_req),
		.mem_we    (c0_we),
		.mem_addr  (c0_addr),
		.mem_wdata (c0_wdata),
		.done      (done0)
	);

	core_pipeline u_core1 (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.prog_we   (prog_we1),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.mem_ack   (c1_ack),
		.mem_rdata (c1_rdata),
		.mem_req   (c1_req),
		.mem_we    (c1_we),
		.mem_addr  (c1_addr),
		.mem_wdata (c1_wdata),
		.done      (done1)
	);

	mem_arbiter u_arbiter (
		.clk       (clk),
		.rst       (rst),
		.req0      (c0_req),
		.we0       (c0_we),
		.addr0     (c0_addr),
		.wdata0    (c0_wdata),
		.req1      (c1_req),
		.we1       (c1_we),
		.addr1     (c1_addr),
		.wdata1    (c1_wdata),
		.ram_rdata (ram_rdata),
		.ack0      (c0_ack),
		.ack1      (c1_ack),
		.rdata0    (c0_rdata),
		.rdata1    (c1_rdata),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata)
	);

	data_ram u_ram (
		.clk      (clk),
		.en       (ram_en),
		.we       (ram_we),
		.addr     (ram_addr),
		.wdata    (ram_wdata),
		.dbg_addr (dbg_addr),
		.rdata    (ram_rdata),
		.dbg_data (dbg_data)
	);

endmodule

`default_nettype wire

// File: tests/tb_dual_core_tests.svh
// core 0 runs every ALU op, core 1 only halts
task alu_operations();
	word_t a;
	word_t b;
	a = 1234;
	b = -567;
	begin_test();
	emit(itype_word(OP_ADDI, 1, 0, 1234));
	emit(itype_word(OP_ADDI, 2, 0, -567));
	emit(rtype_word(OP_ADD, 3, 1, 2));
	emit(rtype_word(OP_SUB, 4, 1, 2));
	emit(rtype_word(OP_AND, 5, 1, 2));
	emit(rtype_word(OP_OR, 6, 1, 2));
	emit(rtype_word(OP_XOR, 7, 1, 2));
	emit(rtype_word(OP_SLT, 8, 1, 2));
	emit(rtype_word(OP_SLT, 9, 2, 1));   // other order, signed
	for (int i = 0; i < 7; i++)
		emit(itype_word(OP_SW, i + 3, 0, 16 + i));
	load_program(1'b0);
	load_program(1'b1);
	run_until_done();
	check_mem(16, a + b);
	check_mem(17, a - b);
	check_mem(18, a & b);
	check_mem(19, a | b);
	check_mem(20, a ^ b);
	check_mem(21, 0);   // 1234 is not below -567
	check_mem(22, 1);
	end_test("alu operations");
endtask

// each result is used by the very next instruction, on core 1
task forwarding_chain();
	word_t v [1:8];
	v[1] = 7;
	v[2] = v[1] + v[1];
	v[3] = v[2] - v[1];
	v[4] = v[3] ^ v[2];
	v[5] = v[4] + sext_const(-100);
	v[6] = v[5] | v[3];
	v[7] = v[6] & v[5];
	v[8] = v[7] + v[7];
	begin_test();
	load_program(1'b0);
	emit(itype_word(OP_ADDI, 1, 0, 7));
	emit(rtype_word(OP_ADD, 2, 1, 1));
	emit(rtype_word(OP_SUB, 3, 2, 1));
	emit(rtype_word(OP_XOR, 4, 3, 2));
	emit(itype_word(OP_ADDI, 5, 4, -100));
	emit(rtype_word(OP_OR, 6, 5, 3));
	emit(rtype_word(OP_AND, 7, 6, 5));
	emit(rtype_word(OP_ADD, 8, 7, 7));
	emit(itype_word(OP_SW, 8, 0, 40));   // store data forwarded
	emit(itype_word(OP_ADDI, 9, 0, 48));
	emit(itype_word(OP_SW, 5, 9, 2));    // base forwarded
	load_program(1'b1);
	run_until_done();
	check_mem(40, v[8]);
	check_mem(50, v[5]);
	end_test("forwarding chain");
endtask

task load_use_stall();
	word_t ld;
	ld = 321;
	begin_test();
	emit(itype_word(OP_ADDI, 1, 0, 321));
	emit(itype_word(OP_SW, 1, 0, 60));
	emit(itype_word(OP_LW, 2, 0, 60));
	emit(itype_word(OP_ADDI, 3, 2, 5));   // uses the load at once
	emit(rtype_word(OP_ADD, 4, 3, 2));
	emit(itype_word(OP_SW, 4, 0, 61));
	emit(itype_word(OP_LW, 5, 0, 61));
	emit(itype_word(OP_SW, 5, 0, 62));    // loaded value as store data
	load_program(1'b0);
	load_program(1'b1);
	run_until_done();
	check_mem(60, ld);
	check_mem(61, ld + 5 + ld);
	check_mem(62, ld + 5 + ld);
	end_test("load-use stall");
endtask

// back to back stores from both cores collide in the arbiter
task shared_memory_arbitration();
	begin_test();
	for (int i = 0; i < 10; i++)
		emit(itype_word(OP_ADDI, i + 1, 0, 1000 + 3 * i));
	for (int i = 0; i < 10; i++)
		emit(itype_word(OP_SW, i + 1, 0, 100 + i));
	load_program(1'b0);
	for (int i = 0; i < 10; i++)
		emit(itype_word(OP_ADDI, i + 1, 0, -(2000 + 7 * i)));
	for (int i = 0; i < 10; i++)
		emit(itype_word(OP_SW, i + 1, 0, 150 + i));
	load_program(1'b1);
	run_until_done();
	for (int i = 0; i < 10; i++) begin
		check_mem(100 + i, 1000 + 3 * i);
		check_mem(150 + i, -(2000 + 7 * i));
	end
	end_test("shared memory arbitration");
endtask

task random_constants();
	word_t r;
	word_t ka;
	word_t kb;
	word_t kc;
	word_t sums [0:3];
	begin_test();
	for (int c = 0; c < 2; c++) begin
		r = lcg_next();
		ka = sext_const(r[14:0]);
		r = lcg_next();
		kb = sext_const(r[14:0]);
		r = lcg_next();
		kc = sext_const(r[14:0]);
		emit(itype_word(OP_ADDI, 1, 0, ka));
		emit(itype_word(OP_ADDI, 2, 0, kb));
		emit(rtype_word(OP_ADD, 3, 1, 2));
		emit(itype_word(OP_ADDI, 4, 3, kc));
		emit(rtype_word(OP_ADD, 5, 4, 4));
		emit(itype_word(OP_SW, 3, 0, 200 + 16 * c));
		emit(itype_word(OP_SW, 5, 0, 201 + 16 * c));
		sums[2 * c] = ka + kb;
		sums[2 * c + 1] = (ka + kb + kc) * 2;
		load_program(c[0]);
	end
	run_until_done();
	for (int c = 0; c < 2; c++) begin
		check_mem(200 + 16 * c, sums[2 * c]);
		check_mem(201 + 16 * c, sums[2 * c + 1]);
	end
	end_test("random constants");
endtask

task reset_state();
	begin_test();
	emit(itype_word(OP_ADDI, 5, 0, 32'h1234));
	emit(itype_word(OP_SW, 5, 0, 230));
	load_program(1'b0);
	emit(itype_word(OP_ADDI, 7, 0, -1));
	emit(itype_word(OP_SW, 7, 0, 231));
	load_program(1'b1);
	run_until_done();
	check_mem(230, 32'h1234);
	check_mem(231, 32'hffff_ffff);
	reset_dut();
	@(negedge clk);
	if (done0 !== 1'b0) begin
		$display("Mismatch at %0t ns: done0 = %b, expected 0", $time, done0);
		errors++;
	end
	if (done1 !== 1'b0) begin
		$display("Mismatch at %0t ns: done1 = %b, expected 0", $time, done1);
		errors++;
	end
	// registers written before the reset must read zero now
	emit(itype_word(OP_SW, 5, 0, 230));
	load_program(1'b0);
	emit(itype_word(OP_SW, 7, 0, 231));
	load_program(1'b1);
	run_until_done();
	check_mem(230, 0);
	check_mem(231, 0);
	end_test("reset state");
endtask

// File: tests/tb_dual_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "dual_core_settings.svh"

module tb_dual_core import core_pkg::*; ();

	localparam int MAX_CYCLES = 3000;   // 6 tests at about 500 cycles each
	localparam int DONE_LIMIT = 500;

	logic clk = 1'b0;
	logic rst;
	logic run;
	logic prog_we;
	logic prog_core;
	pc_t prog_addr;
	word_t prog_data;
	dmem_addr_t dbg_addr;
	word_t dbg_data;
	logic done0;
	logic done1;

	word_t prog [0:(1<<`IMEM_ADDR_W)-1];   // program being built
	int plen = 0;
	int errors = 0;
	int err_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	word_t lcg_state = 32'h89e3;

	dual_core_top u_dual_core_top (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.prog_we   (prog_we),
		.prog_core (prog_core),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.dbg_addr  (dbg_addr),
		.dbg_data  (dbg_data),
		.done0     (done0),
		.done1     (done1)
	);

	always #20 clk = ~clk;

	// hard stop for the whole run
	always @(posedge clk) begin
		cycles++;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: simulation ran for %0d cycles without finishing", MAX_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t sext_const(input logic [`IMM_W-1:0] k);
		return {{(`DATA_W-`IMM_W){k[`IMM_W-1]}}, k};
	endfunction

	// opcode, spare bit, rs, rt, rd, unused low bits
	function automatic word_t rtype_word(input op_t op, input int rd, input int rs, input int rt);
		return {op, 1'b0, rs[4:0], rt[4:0], rd[4:0], 10'd0};
	endfunction

	function automatic word_t itype_word(input op_t op, input int rt, input int rs, input int imm);
		return {op, 1'b0, rs[4:0], rt[4:0], imm[14:0]};
	endfunction

	task emit(input word_t w);
		prog[plen] = w;
		plen++;
	endtask

	// writes the buffered program plus a closing halt word
	task load_program(input logic core);
		prog[plen] = 32'h0;
		for (int i = 0; i <= plen; i++) begin
			@(posedge clk);
			prog_we <= 1'b1;
			prog_core <= core;
			prog_addr <= i[`IMEM_ADDR_W-1:0];
			prog_data <= prog[i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		plen = 0;
	endtask

	task reset_dut();
		@(posedge clk);
		rst <= 1'b1;
		run <= 1'b0;
		prog_we <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	endtask

	task run_until_done();
		int waited;
		waited = 0;
		@(posedge clk);
		run <= 1'b1;
		@(negedge clk);
		while (!(done0 === 1'b1 && done1 === 1'b1) && waited < DONE_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (waited >= DONE_LIMIT) begin
			$display("error at %0t ns: cores never raised both done flags", $time);
			errors++;
		end
		@(posedge clk);
		run <= 1'b0;
	endtask

	task check_mem(input int addr, input word_t expected);
		@(posedge clk);
		dbg_addr <= addr[`DMEM_ADDR_W-1:0];
		@(negedge clk);   // inspection read is combinational
		if (dbg_data !== expected) begin
			$display("Mismatch at %0t ns: dbg_data[%0d] = %h, expected %h",
				$time, addr, dbg_data, expected);
			errors++;
		end
	endtask

	task begin_test();
		reset_dut();
		err_start = errors;
	endtask

	task end_test(input string name);
		tests_run++;
		if (errors == err_start) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - err_start);
		end
	endtask

`include "tb_dual_core_tests.svh"

	initial begin
		rst = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_core = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		dbg_addr = '0;
		alu_operations();
		forwarding_chain();
		load_use_stall();
		shared_memory_arbitration();
		random_constants();
		reset_state();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
+incdir+tests
common/core_pkg.sv
core/core_alu.sv
core/core_pipeline.sv
hdl/mem_arbiter.sv
hdl/data_ram.sv
hdl/dual_core_top.sv
tests/tb_dual_core.sv

// File: Bender.yml
package:
  name: dual_core

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - core/core_alu.sv
      - core/core_pipeline.sv
      - hdl/mem_arbiter.sv
      - hdl/data_ram.sv
      - hdl/dual_core_top.sv
  - target: test
    include_dirs:
      - common
      - tests
    files:
      - tests/tb_dual_core.sv
